//--- Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module msg_rx_tb \
		-Mdir obj_dir -o msg_rx_sim

run: compile
	./obj_dir/msg_rx_sim | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- all.f
+incdir+sim
source/msg_rx_pkg.sv
source/axi_wr_front.sv
source/frag_sequencer.sv
source/payload_store.sv
source/msg_sram_writer.sv
source/pcie_msg_rx_top.sv
sim/msg_rx_tb.sv

//--- sim/msg_rx_vectors.svh
/*
 * Test table: test rows with expected outcomes, fragment rows
 * with type, SN, tag, version, beat count and awaddr
 */
`ifndef MSG_RX_VECTORS_SVH
`define MSG_RX_VECTORS_SVH

localparam int MAX_TESTS = 8;
localparam int MAX_FRAGS = 32;

string      test_name  [MAX_TESTS];
int         test_asm   [MAX_TESTS];
int         test_tag   [MAX_TESTS];
int         test_bad   [MAX_TESTS];
int         test_hold  [MAX_TESTS];
int         frag_test  [MAX_FRAGS];
frag_type_e frag_kind  [MAX_FRAGS];
int         frag_sn    [MAX_FRAGS];
int         frag_tag   [MAX_FRAGS];
int         frag_ver   [MAX_FRAGS];
int         frag_beats [MAX_FRAGS];
int         frag_addr  [MAX_FRAGS];
int         num_tests;
int         num_frags;

// Assemblies expected, last assembled tag, bad_ver_count after the test, bready hold cycles
task automatic add_test(input string name, input int n_asm, input int tag, input int bad,
                        input int hold);
    test_name[num_tests] = name;
    test_asm[num_tests]  = n_asm;
    test_tag[num_tests]  = tag;
    test_bad[num_tests]  = bad;
    test_hold[num_tests] = hold;
    num_tests++;
endtask

// Fragment of the most recently added test
task automatic add_frag(input frag_type_e kind, input int sn, input int tag, input int ver,
                        input int beats, input int addr);
    frag_test[num_frags]  = num_tests - 1;
    frag_kind[num_frags]  = kind;
    frag_sn[num_frags]    = sn;
    frag_tag[num_frags]   = tag;
    frag_ver[num_frags]   = ver;
    frag_beats[num_frags] = beats;
    frag_addr[num_frags]  = addr;
    num_frags++;
endtask

task automatic load_table();
    num_tests = 0;
    num_frags = 0;
    add_test("single_sg", 1, 1, 0, 0);
    add_frag(FRAG_SG, 0, 1, 1, 4, 'h010);
    add_test("s_m_l_sequence", 1, 2, 0, 0);
    add_frag(FRAG_S,  0, 2, 1, 3, 'h040);
    add_frag(FRAG_M,  1, 2, 1, 4, 'h040);
    add_frag(FRAG_L,  2, 2, 1, 2, 'h080);
    add_test("bad_version", 0, 0, 1, 2);
    add_frag(FRAG_SG, 0, 0, 3, 3, 'h100);
    // Wrong SN on M and an L on an idle tag, then the proper sequence
    add_test("bad_sn_then_ok", 1, 3, 1, 0);
    add_frag(FRAG_S,  0, 3, 1, 3, 'h120);
    add_frag(FRAG_M,  2, 3, 1, 3, 'h120);
    add_frag(FRAG_L,  1, 0, 1, 2, 'h130);
    add_frag(FRAG_M,  1, 3, 1, 3, 'h120);
    add_frag(FRAG_L,  2, 3, 1, 2, 'h140);
    add_test("interleaved_tags", 2, 1, 1, 0);
    add_frag(FRAG_S,  0, 0, 1, 3, 'h200);
    add_frag(FRAG_S,  0, 1, 1, 2, 'h210);
    add_frag(FRAG_L,  1, 0, 1, 3, 'h200);
    add_frag(FRAG_L,  1, 1, 1, 4, 'h240);
    add_test("bad_tag_stall", 0, 0, 1, 4);
    add_frag(FRAG_SG, 0, 5, 1, 3, 'h300);
    add_frag(FRAG_SG, 0, 9, 1, 2, 'h310);
endtask

`endif

//--- sim/msg_rx_tb.sv
/*
 * Testbench for the message fragment receiver with clock, reset, AXI driver,
 * SRAM and assembly monitor, reference model, checks and watchdog
 */
`timescale 1ns/1ps

module msg_rx_tb
    import msg_rx_pkg::*;
();

    localparam int CLK_PERIOD = 4;
    localparam int NUM_TAGS   = 4;
    localparam int MSG_BEATS  = 32;

    logic               clk;
    logic               rst_n;
    logic               awvalid;
    logic [31:0]        awaddr;
    logic [7:0]         awlen;
    logic               awready;
    logic               wvalid;
    logic [127:0]       wdata;
    logic               wlast;
    logic               wready;
    logic               bvalid;
    logic [1:0]         bresp;
    logic               bready;
    logic               sram_wen;
    logic [SRAM_AW-1:0] sram_waddr;
    logic [127:0]       sram_wdata;
    logic               assembled_valid;
    logic [TAG_W-1:0]   assembled_tag;
    logic [127:0]       assembled_header;
    logic [7:0]         bad_ver_count;

    `include "msg_rx_vectors.svh"

    logic [31:0]        lfsr_state = 32'h7f64_4c3c;
    logic [127:0]       cur_beat [16];
    logic [127:0]       mdl_pay [NUM_TAGS][MSG_BEATS];
    int                 mdl_len [NUM_TAGS];
    int                 mdl_sn [NUM_TAGS];
    bit                 mdl_active [NUM_TAGS];
    logic [SRAM_AW-1:0] exp_waddr [$];
    logic [127:0]       exp_wdata [$];
    logic [127:0]       exp_hdr [$];
    int                 exp_tag [$];
    logic [SRAM_AW-1:0] got_waddr [$];
    logic [127:0]       got_wdata [$];
    logic [127:0]       got_hdr [$];
    int                 got_tag [$];
    int                 cur_test;
    int                 test_errors;
    int                 tests_failed;
    int                 watch_cycles;
    bit                 table_ready;

    pcie_msg_rx_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [127:0] rand_bits(input int n);
        logic [127:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[126:0], lfsr_bit()};
        end
        return v;
    endfunction

    // SRAM write and assembly monitor
    always @(negedge clk) begin
        if (rst_n && sram_wen) begin
            got_waddr.push_back(sram_waddr);
            got_wdata.push_back(sram_wdata);
        end
        if (rst_n && assembled_valid) begin
            got_tag.push_back(int'(assembled_tag));
            got_hdr.push_back(assembled_header);
        end
    end

    task automatic report_error(input string what, input logic [127:0] exp,
                                input logic [127:0] act);
        $display("error %s %s: expected %0h, actual %0h", test_name[cur_test], what, exp, act);
        test_errors++;
    endtask

    task automatic append_payload(input int t, input int n);
        for (int i = 1; i < n; i++) begin
            mdl_pay[t][mdl_len[t]] = cur_beat[i];
            mdl_len[t]++;
        end
    endtask

    task automatic complete_message(input int t, input int f);
        for (int i = 0; i < mdl_len[t]; i++) begin
            exp_waddr.push_back(SRAM_AW'(frag_addr[f] + i));
            exp_wdata.push_back(mdl_pay[t][i]);
        end
        exp_hdr.push_back(cur_beat[0]);
        exp_tag.push_back(t);
        mdl_active[t] = 1'b0;
        mdl_sn[t]     = 0;
    endtask

    // Reference model of tag sequencing and message assembly
    task automatic model_fragment(input int f);
        int  t;
        bit  match;
        t = frag_tag[f];
        if (frag_ver[f] == int'(HDR_VERSION) && t < NUM_TAGS) begin
            match = mdl_active[t] && frag_sn[f] == mdl_sn[t];
            case (frag_kind[f])
                FRAG_S: begin
                    if (frag_sn[f] == 0) begin
                        mdl_active[t] = 1'b1;
                        mdl_sn[t]     = 1;
                        mdl_len[t]    = 0;
                        append_payload(t, frag_beats[f]);
                    end
                end
                FRAG_M: begin
                    if (match) begin
                        append_payload(t, frag_beats[f]);
                        mdl_sn[t] = (mdl_sn[t] + 1) % 4;
                    end
                end
                FRAG_L: begin
                    if (match) begin
                        append_payload(t, frag_beats[f]);
                        complete_message(t, f);
                    end
                end
                default: begin
                    mdl_len[t] = 0;
                    append_payload(t, frag_beats[f]);
                    complete_message(t, f);
                end
            endcase
        end
    endtask

    task automatic send_fragment(input int f);
        int n;
        n = frag_beats[f];
        cur_beat[0] = rand_bits(128);
        cur_beat[0][127:126] = frag_kind[f];
        cur_beat[0][125:124] = frag_sn[f][1:0];
        cur_beat[0][123:120] = frag_tag[f][3:0];
        cur_beat[0][99:96]   = frag_ver[f][3:0];
        for (int i = 1; i < n; i++) begin
            cur_beat[i] = rand_bits(128);
        end
        model_fragment(f);
        if (test_hold[cur_test] > 0) begin
            bready = 1'b0;
        end
        @(negedge clk);
        awvalid = 1'b1;
        awaddr  = 32'(frag_addr[f]);
        awlen   = 8'(n - 1);
        while (!awready) @(negedge clk);
        @(negedge clk);
        awvalid = 1'b0;
        for (int i = 0; i < n; i++) begin
            wvalid = 1'b1;
            wdata  = cur_beat[i];
            wlast  = (i == n - 1);
            while (!wready) @(negedge clk);
            @(negedge clk);
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
        while (!bvalid) @(negedge clk);
        if (bresp != AXI_RESP_OKAY) begin
            report_error("bresp", AXI_RESP_OKAY, bresp);
        end
        repeat (test_hold[cur_test]) begin
            @(negedge clk);
            if (!bvalid || awready) begin
                $display("%s: response dropped or new address accepted while bready low",
                         test_name[cur_test]);
                test_errors++;
            end
        end
        bready = 1'b1;
        @(negedge clk);
    endtask

    task automatic check_results(input int t);
        if (got_waddr.size() != exp_waddr.size()) begin
            report_error("sram write count", exp_waddr.size(), got_waddr.size());
        end else begin
            for (int i = 0; i < exp_waddr.size(); i++) begin
                if (got_waddr[i] != exp_waddr[i]) begin
                    report_error($sformatf("sram addr %0d", i), exp_waddr[i], got_waddr[i]);
                end
                if (got_wdata[i] != exp_wdata[i]) begin
                    report_error($sformatf("sram data %0d", i), exp_wdata[i], got_wdata[i]);
                end
            end
        end
        if (got_tag.size() != test_asm[t]) begin
            report_error("assembly count", test_asm[t], got_tag.size());
        end else if (test_asm[t] > 0 && got_tag[$] != test_tag[t]) begin
            report_error("assembled tag", test_tag[t], got_tag[$]);
        end
        if (got_hdr.size() == exp_hdr.size()) begin
            for (int i = 0; i < exp_hdr.size(); i++) begin
                if (got_hdr[i] != exp_hdr[i]) begin
                    report_error($sformatf("assembled header %0d", i), exp_hdr[i], got_hdr[i]);
                end
                if (got_tag[i] != exp_tag[i]) begin
                    report_error($sformatf("assembled tag %0d", i), exp_tag[i], got_tag[i]);
                end
            end
        end else begin
            report_error("assembled header count", exp_hdr.size(), got_hdr.size());
        end
        if (bad_ver_count != 8'(test_bad[t])) begin
            report_error("bad_ver_count", test_bad[t], bad_ver_count);
        end
    endtask

    initial begin
        rst_n   = 1'b0;
        awvalid = 1'b0;
        awaddr  = '0;
        awlen   = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wlast   = 1'b0;
        bready  = 1'b0;
        tests_failed = 0;
        load_table();
        watch_cycles = 0;
        for (int f = 0; f < num_frags; f++) begin
            watch_cycles += frag_beats[f] * 20;
        end
        table_ready = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n  = 1'b1;
        bready = 1'b1;
        for (int t = 0; t < num_tests; t++) begin
            cur_test    = t;
            test_errors = 0;
            exp_waddr.delete();
            exp_wdata.delete();
            exp_hdr.delete();
            exp_tag.delete();
            got_waddr.delete();
            got_wdata.delete();
            got_hdr.delete();
            got_tag.delete();
            for (int f = 0; f < num_frags; f++) begin
                if (frag_test[f] == t) begin
                    send_fragment(f);
                end
            end
            check_results(t);
            if (test_errors == 0) begin
                $display("test %s: ok", test_name[t]);
            end else begin
                $display("test %s: %0d errors", test_name[t], test_errors);
                tests_failed++;
            end
        end
        $display("tests run %0d, passed %0d, failed %0d", num_tests,
                 num_tests - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        repeat (watch_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not finish", watch_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- source/axi_wr_front.sv
/*
 * AXI write slave front end: fragment buffer, header field decode,
 * version and tag checks, bad version counter and write response
 */
`timescale 1ns/1ps

module axi_wr_front
    import msg_rx_pkg::*;
#(
    parameter int DATA_W         = 128,
    parameter int NUM_TAGS       = 4,
    parameter int MAX_FRAG_BEATS = 16,
    localparam int FB_W          = $clog2(MAX_FRAG_BEATS + 1),
    localparam int BA_W          = $clog2(MAX_FRAG_BEATS)
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                awvalid,
    input  logic [31:0]         awaddr,
    input  logic [7:0]          awlen,
    output logic                awready,
    input  logic                wvalid,
    input  logic [DATA_W-1:0]   wdata,
    input  logic                wlast,
    output logic                wready,
    output logic                bvalid,
    output logic [1:0]          bresp,
    input  logic                bready,
    input  logic                done,
    input  logic [BA_W-1:0]     buf_raddr,
    output logic                frag_start,
    output frag_type_e          frag_type,
    output logic [SN_W-1:0]     frag_sn,
    output logic [TAG_W-1:0]    frag_tag,
    output logic [FB_W-1:0]     frag_beats,
    output logic [127:0]        frag_header,
    output logic [SRAM_AW-1:0]  wr_addr,
    output logic [DATA_W-1:0]   buf_rdata,
    output logic [7:0]          bad_ver_count
);

    front_state_e      state;
    logic [FB_W-1:0]   beat_cnt;
    logic [DATA_W-1:0] frag_buf [MAX_FRAG_BEATS];
    logic              ver_ok;
    logic              tag_ok;
    logic              beat_room;

    // Header fields decoded from the captured beat 0
    assign frag_type = frag_type_e'(frag_header[FRAG_TYPE_HI -: $bits(frag_type_e)]);
    assign frag_sn   = frag_header[SN_HI -: SN_W];
    assign frag_tag  = frag_header[TAG_HI -: TAG_W];
    assign ver_ok    = (frag_header[VER_HI -: VER_W] == HDR_VERSION);
    assign tag_ok    = (int'(frag_tag) < NUM_TAGS);
    assign beat_room = (int'(beat_cnt) < MAX_FRAG_BEATS);
    assign bresp     = AXI_RESP_OKAY;

    // Fragment buffer, read back by the payload store
    always_ff @(posedge clk) begin
        if (state == FS_DATA && wvalid && wready && beat_room) begin
            frag_buf[beat_cnt[BA_W-1:0]] <= wdata;
            if (beat_cnt == '0) begin
                frag_header <= wdata[127:0];
            end
        end
        buf_rdata <= frag_buf[buf_raddr];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= FS_IDLE;
            awready       <= 1'b0;
            wready        <= 1'b0;
            bvalid        <= 1'b0;
            frag_start    <= 1'b0;
            beat_cnt      <= '0;
            frag_beats    <= '0;
            wr_addr       <= '0;
            bad_ver_count <= '0;
        end else begin
            frag_start <= 1'b0;
            case (state)
                FS_IDLE: begin
                    awready <= 1'b1;
                    if (awvalid && awready) begin
                        awready    <= 1'b0;
                        wready     <= 1'b1;
                        wr_addr    <= awaddr[SRAM_AW-1:0];
                        frag_beats <= FB_W'(awlen) + 1'b1;
                        beat_cnt   <= '0;
                        state      <= FS_DATA;
                    end
                end
                FS_DATA: begin
                    if (wvalid && wready) begin
                        // Beats past the buffer depth are dropped
                        if (beat_room) begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                        if (wlast) begin
                            wready <= 1'b0;
                            state  <= FS_CHECK;
                        end
                    end
                end
                FS_CHECK: begin
                    if (!ver_ok) begin
                        if (bad_ver_count != 8'hff) begin
                            bad_ver_count <= bad_ver_count + 1'b1;
                        end
                        bvalid <= 1'b1;
                        state  <= FS_RESP;
                    end else if (!tag_ok) begin
                        bvalid <= 1'b1;
                        state  <= FS_RESP;
                    end else begin
                        frag_start <= 1'b1;
                        state      <= FS_WAIT_DONE;
                    end
                end
                FS_WAIT_DONE: begin
                    if (done) begin
                        bvalid <= 1'b1;
                        state  <= FS_RESP;
                    end
                end
                FS_RESP: begin
                    if (bready) begin
                        bvalid <= 1'b0;
                        state  <= FS_IDLE;
                    end
                end
                default: state <= FS_IDLE;
            endcase
        end
    end

    // B channel must hold until the master takes it
    assert property (@(posedge clk) disable iff (!rst_n) bvalid && !bready |=> bvalid);

endmodule

//--- source/frag_sequencer.sv
/*
 * Per-tag fragment sequencing and accept/complete verdict
 */
`timescale 1ns/1ps

module frag_sequencer
    import msg_rx_pkg::*;
#(
    parameter int NUM_TAGS = 4,
    localparam int TIX_W   = $clog2(NUM_TAGS)
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             frag_start,
    input  frag_type_e       frag_type,
    input  logic [SN_W-1:0]  frag_sn,
    input  logic [TAG_W-1:0] frag_tag,
    output logic             verdict_valid,
    output logic             verdict_accept,
    output logic             verdict_complete
);

    logic [NUM_TAGS-1:0] active;
    logic [SN_W-1:0]     exp_sn [NUM_TAGS];
    logic [TIX_W-1:0]    tag_idx;
    logic                sn_match;
    logic                accept;
    logic                complete;

    assign tag_idx  = frag_tag[TIX_W-1:0];
    assign sn_match = active[tag_idx] && (frag_sn == exp_sn[tag_idx]);

    always_comb begin
        accept   = 1'b0;
        complete = 1'b0;
        case (frag_type)
            FRAG_S:  accept = (frag_sn == '0);
            FRAG_M:  accept = sn_match;
            FRAG_L: begin
                accept   = sn_match;
                complete = sn_match;
            end
            FRAG_SG: begin
                accept   = 1'b1;
                complete = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active           <= '0;
            exp_sn           <= '{default: '0};
            verdict_valid    <= 1'b0;
            verdict_accept   <= 1'b0;
            verdict_complete <= 1'b0;
        end else begin
            verdict_valid <= frag_start;
            if (frag_start) begin
                verdict_accept   <= accept;
                verdict_complete <= complete;
                if (accept) begin
                    case (frag_type)
                        FRAG_S: begin
                            active[tag_idx] <= 1'b1;
                            exp_sn[tag_idx] <= SN_W'(1);
                        end
                        // SN wraps at two bits
                        FRAG_M: exp_sn[tag_idx] <= exp_sn[tag_idx] + 1'b1;
                        default: begin
                            active[tag_idx] <= 1'b0;
                            exp_sn[tag_idx] <= '0;
                        end
                    endcase
                end
            end
        end
    end

endmodule

//--- source/msg_rx_pkg.sv
/*
 * Shared types and constants for the message fragment receiver:
 * fragment type and FSM state enums, header field positions, widths
 */
package msg_rx_pkg;

    // Fragment type, taken from the top two header bits
    typedef enum logic [1:0] {
        FRAG_M  = 2'b00,
        FRAG_L  = 2'b01,
        FRAG_S  = 2'b10,
        FRAG_SG = 2'b11
    } frag_type_e;

    typedef enum logic [2:0] {
        FS_IDLE,
        FS_DATA,
        FS_CHECK,
        FS_WAIT_DONE,
        FS_RESP
    } front_state_e;

    typedef enum logic [1:0] {
        WS_IDLE,
        WS_WRITE,
        WS_DONE
    } writer_state_e;

    // Header field positions (MSB of each field)
    localparam int FRAG_TYPE_HI = 127;
    localparam int SN_HI        = 125;
    localparam int TAG_HI       = 123;
    localparam int VER_HI       = 99;

    localparam int TAG_W   = 4;
    localparam int SN_W    = 2;
    localparam int VER_W   = 4;
    localparam int SRAM_AW = 10;

    localparam logic [VER_W-1:0] HDR_VERSION   = 4'd1;
    localparam logic [1:0]       AXI_RESP_OKAY = 2'b00;

endpackage

//--- source/msg_sram_writer.sv
/*
 * Joins the sequencer verdict with copy completion and drains
 * an assembled message from the payload store into the SRAM port
 */
`timescale 1ns/1ps

module msg_sram_writer
    import msg_rx_pkg::*;
#(
    parameter int DATA_W        = 128,
    parameter int MAX_MSG_BEATS = 32,
    localparam int OFF_W        = $clog2(MAX_MSG_BEATS),
    localparam int LEN_W        = $clog2(MAX_MSG_BEATS + 1)
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [TAG_W-1:0]   frag_tag,
    input  logic [127:0]       frag_header,
    input  logic [SRAM_AW-1:0] wr_addr,
    input  logic               verdict_valid,
    input  logic               verdict_accept,
    input  logic               verdict_complete,
    input  logic               copy_done,
    input  logic [LEN_W-1:0]   committed_len,
    input  logic [DATA_W-1:0]  rd_data,
    output logic [OFF_W-1:0]   rd_addr,
    output logic               sram_wen,
    output logic [SRAM_AW-1:0] sram_waddr,
    output logic [DATA_W-1:0]  sram_wdata,
    output logic               assembled_valid,
    output logic [TAG_W-1:0]   assembled_tag,
    output logic [127:0]       assembled_header,
    output logic               done
);

    writer_state_e    state;
    logic             seen_verdict;
    logic             seen_copy;
    logic             msg_ok;
    logic             go_ok;
    logic [LEN_W-1:0] rd_idx;
    logic [LEN_W-1:0] wr_idx;
    logic             rd_vld;
    logic             more;

    // Verdict and copy end may arrive in either order
    assign go_ok = verdict_valid ? (verdict_accept && verdict_complete) : msg_ok;
    assign more  = (rd_idx < committed_len);

    assign rd_addr          = rd_idx[OFF_W-1:0];
    assign sram_wen         = (state == WS_WRITE) && rd_vld;
    assign sram_waddr       = wr_addr + SRAM_AW'(wr_idx);
    assign sram_wdata       = rd_data;
    assign assembled_valid  = sram_wen && (wr_idx == committed_len - 1'b1);
    assign assembled_tag    = frag_tag;
    assign assembled_header = frag_header;
    assign done             = (state == WS_DONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= WS_IDLE;
            seen_verdict <= 1'b0;
            seen_copy    <= 1'b0;
            msg_ok       <= 1'b0;
            rd_idx       <= '0;
            wr_idx       <= '0;
            rd_vld       <= 1'b0;
        end else begin
            case (state)
                WS_IDLE: begin
                    if (verdict_valid) begin
                        seen_verdict <= 1'b1;
                        msg_ok       <= verdict_accept && verdict_complete;
                    end
                    if (copy_done) begin
                        seen_copy <= 1'b1;
                    end
                    if ((seen_verdict || verdict_valid) && (seen_copy || copy_done)) begin
                        seen_verdict <= 1'b0;
                        seen_copy    <= 1'b0;
                        rd_idx       <= '0;
                        rd_vld       <= 1'b0;
                        state        <= go_ok ? WS_WRITE : WS_DONE;
                    end
                end
                WS_WRITE: begin
                    // One cycle read latency from the store
                    rd_vld <= more;
                    wr_idx <= rd_idx;
                    if (more) begin
                        rd_idx <= rd_idx + 1'b1;
                    end
                    if (committed_len == '0 || assembled_valid) begin
                        state <= WS_DONE;
                    end
                end
                WS_DONE: state <= WS_IDLE;
                default: state <= WS_IDLE;
            endcase
        end
    end

    // Writes stay inside the assembled message
    assert property (@(posedge clk) disable iff (!rst_n)
        sram_wen |-> (wr_idx < committed_len));

endmodule

//--- source/payload_store.sv
/*
 * Per-tag payload memory, filled from the fragment buffer,
 * with committed message length per tag and a read port for the writer
 */
`timescale 1ns/1ps

module payload_store
    import msg_rx_pkg::*;
#(
    parameter int DATA_W         = 128,
    parameter int NUM_TAGS       = 4,
    parameter int MAX_FRAG_BEATS = 16,
    parameter int MAX_MSG_BEATS  = 32,
    localparam int FB_W          = $clog2(MAX_FRAG_BEATS + 1),
    localparam int BA_W          = $clog2(MAX_FRAG_BEATS),
    localparam int OFF_W         = $clog2(MAX_MSG_BEATS),
    localparam int LEN_W         = $clog2(MAX_MSG_BEATS + 1),
    localparam int TIX_W         = $clog2(NUM_TAGS)
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              frag_start,
    input  frag_type_e        frag_type,
    input  logic [TAG_W-1:0]  frag_tag,
    input  logic [FB_W-1:0]   frag_beats,
    input  logic [DATA_W-1:0] buf_rdata,
    input  logic              verdict_valid,
    input  logic              verdict_accept,
    input  logic [OFF_W-1:0]  rd_addr,
    output logic [BA_W-1:0]   buf_raddr,
    output logic              copy_done,
    output logic [LEN_W-1:0]  committed_len,
    output logic [DATA_W-1:0] rd_data
);

    logic [DATA_W-1:0] mem [NUM_TAGS][MAX_MSG_BEATS];
    logic [LEN_W-1:0]  committed [NUM_TAGS];
    logic [TIX_W-1:0]  tag_idx;
    logic [LEN_W-1:0]  base_len;
    logic [LEN_W-1:0]  end_len;
    logic [LEN_W-1:0]  wr_off;
    logic [FB_W-1:0]   rd_idx;
    logic              rd_act;
    logic              wr_vld;

    assign tag_idx       = frag_tag[TIX_W-1:0];
    assign committed_len = committed[tag_idx];
    assign buf_raddr     = rd_idx[BA_W-1:0];

    // S and SG restart the region, M and L append
    assign base_len = (frag_type == FRAG_S || frag_type == FRAG_SG) ? '0 : committed[tag_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            committed <= '{default: '0};
            rd_act    <= 1'b0;
            rd_idx    <= '0;
            wr_vld    <= 1'b0;
            wr_off    <= '0;
            end_len   <= '0;
            copy_done <= 1'b0;
        end else begin
            copy_done <= 1'b0;
            wr_vld    <= rd_act;
            if (frag_start) begin
                // Beat 0 is the header and is skipped
                rd_act    <= (frag_beats > FB_W'(1));
                rd_idx    <= FB_W'(1);
                wr_off    <= base_len;
                end_len   <= base_len + LEN_W'(frag_beats) - 1'b1;
                copy_done <= (frag_beats <= FB_W'(1));
            end else if (rd_act) begin
                rd_idx <= rd_idx + 1'b1;
                if (rd_idx == frag_beats - 1'b1) begin
                    rd_act    <= 1'b0;
                    copy_done <= 1'b1;
                end
            end
            if (wr_vld) begin
                wr_off <= wr_off + 1'b1;
            end
            if (verdict_valid && verdict_accept) begin
                committed[tag_idx] <= end_len;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_vld) begin
            mem[tag_idx][wr_off[OFF_W-1:0]] <= buf_rdata;
        end
        rd_data <= mem[tag_idx][rd_addr];
    end

    // Appended payload must fit in the tag region
    assert property (@(posedge clk) disable iff (!rst_n)
        wr_vld |-> (int'(wr_off) < MAX_MSG_BEATS));

endmodule

//--- source/pcie_msg_rx_top.sv
/*
 * Message fragment receiver top level: front end, sequencer,
 * payload store and SRAM writer
 */
`timescale 1ns/1ps

module pcie_msg_rx_top
    import msg_rx_pkg::*;
#(
    parameter int DATA_W         = 128,
    parameter int NUM_TAGS       = 4,
    parameter int MAX_FRAG_BEATS = 16,
    parameter int MAX_MSG_BEATS  = 32
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               awvalid,
    input  logic [31:0]        awaddr,
    input  logic [7:0]         awlen,
    output logic               awready,
    input  logic               wvalid,
    input  logic [DATA_W-1:0]  wdata,
    input  logic               wlast,
    output logic               wready,
    output logic               bvalid,
    output logic [1:0]         bresp,
    input  logic               bready,
    output logic               sram_wen,
    output logic [SRAM_AW-1:0] sram_waddr,
    output logic [DATA_W-1:0]  sram_wdata,
    output logic               assembled_valid,
    output logic [TAG_W-1:0]   assembled_tag,
    output logic [127:0]       assembled_header,
    output logic [7:0]         bad_ver_count
);

    localparam int FB_W  = $clog2(MAX_FRAG_BEATS + 1);
    localparam int BA_W  = $clog2(MAX_FRAG_BEATS);
    localparam int OFF_W = $clog2(MAX_MSG_BEATS);
    localparam int LEN_W = $clog2(MAX_MSG_BEATS + 1);

    logic               frag_start;
    frag_type_e         frag_type;
    logic [SN_W-1:0]    frag_sn;
    logic [TAG_W-1:0]   frag_tag;
    logic [FB_W-1:0]    frag_beats;
    logic [127:0]       frag_header;
    logic [SRAM_AW-1:0] wr_addr;
    logic [BA_W-1:0]    buf_raddr;
    logic [DATA_W-1:0]  buf_rdata;
    logic               done;
    logic               verdict_valid;
    logic               verdict_accept;
    logic               verdict_complete;
    logic               copy_done;
    logic [LEN_W-1:0]   committed_len;
    logic [OFF_W-1:0]   rd_addr;
    logic [DATA_W-1:0]  rd_data;

    axi_wr_front #(
        .DATA_W         (DATA_W),
        .NUM_TAGS       (NUM_TAGS),
        .MAX_FRAG_BEATS (MAX_FRAG_BEATS)
    ) u_front (
        .clk, .rst_n,
        .awvalid, .awaddr, .awlen, .awready,
        .wvalid, .wdata, .wlast, .wready,
        .bvalid, .bresp, .bready,
        .done, .buf_raddr,
        .frag_start, .frag_type, .frag_sn, .frag_tag, .frag_beats, .frag_header,
        .wr_addr, .buf_rdata, .bad_ver_count
    );

    frag_sequencer #(
        .NUM_TAGS (NUM_TAGS)
    ) u_seq (
        .clk, .rst_n,
        .frag_start, .frag_type, .frag_sn, .frag_tag,
        .verdict_valid, .verdict_accept, .verdict_complete
    );

    payload_store #(
        .DATA_W         (DATA_W),
        .NUM_TAGS       (NUM_TAGS),
        .MAX_FRAG_BEATS (MAX_FRAG_BEATS),
        .MAX_MSG_BEATS  (MAX_MSG_BEATS)
    ) u_store (
        .clk, .rst_n,
        .frag_start, .frag_type, .frag_tag, .frag_beats, .buf_rdata,
        .verdict_valid, .verdict_accept, .rd_addr,
        .buf_raddr, .copy_done, .committed_len, .rd_data
    );

    msg_sram_writer #(
        .DATA_W        (DATA_W),
        .MAX_MSG_BEATS (MAX_MSG_BEATS)
    ) u_writer (
        .clk, .rst_n,
        .frag_tag, .frag_header, .wr_addr,
        .verdict_valid, .verdict_accept, .verdict_complete,
        .copy_done, .committed_len, .rd_data, .rd_addr,
        .sram_wen, .sram_waddr, .sram_wdata,
        .assembled_valid, .assembled_tag, .assembled_header, .done
    );

endmodule
